/* hdl/wb_pkg.sv */
`default_nettype none

package wb_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;
  localparam int WAIT_W = 4;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] word_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [WAIT_W-1:0] wait_t;

  // Memory map, one 4 KiB page per slave
  localparam int RAM_WORDS = 1024;
  localparam int RAM_IDX_W = $clog2(RAM_WORDS);
  localparam int PAGE_LSB = 12;
  localparam addr_t RAM_BASE = 32'h0000_0000;
  localparam addr_t REG_BASE = 32'h1000_0000;

  localparam logic [PAGE_LSB-1:0] REG_WAIT_OFS = 12'h000;
  localparam logic [PAGE_LSB-1:0] REG_SCRATCH_OFS = 12'h004;
  localparam logic [PAGE_LSB-1:0] REG_COUNT_OFS = 12'h008;

  typedef struct packed {
    logic  valid;
    addr_t addr;
    word_t wdata;
    strb_t wstrb;
  } cpu_req_t;

  typedef struct packed {
    word_t rdata;
    logic  ready;
  } cpu_rsp_t;

  typedef struct packed {
    addr_t adr;
    word_t dat;
    strb_t sel;
    logic  we;
    logic  cyc;
    logic  stb;
  } wb_req_t;

  typedef struct packed {
    word_t dat;
    logic  ack;
    logic  stall;
  } wb_rsp_t;

  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    STORE
  } bridge_state_e;

endpackage

`default_nettype wire

/* hdl/wb_master_bridge.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_master_bridge (
  input  wire              clock,
  input  wire              reset,
  input  wb_pkg::cpu_req_t cpu_req_i,
  output wb_pkg::cpu_rsp_t cpu_rsp_o,
  output wb_pkg::wb_req_t  wb_req_o,
  input  wb_pkg::wb_rsp_t  wb_rsp_i
);

  wb_pkg::bridge_state_e state_q;
  wb_pkg::bridge_state_e state_d;

  wb_pkg::wb_req_t req_q;
  wb_pkg::wb_req_t req_d;

  logic ready_q;
  logic ready_d;
  wb_pkg::word_t rdata_q;

  logic is_read;
  logic load_ack;

  // No strobes set means a load
  assign is_read = (cpu_req_i.wstrb == '0);
  assign load_ack = (state_q == wb_pkg::LOAD) && wb_rsp_i.ack;

  always_comb begin
    state_d = state_q;
    req_d = req_q;
    ready_d = 1'b0;
    case (state_q)
      wb_pkg::IDLE: begin
        // Hold off during the ready cycle, valid is still up from the last request
        if (cpu_req_i.valid && !ready_q) begin
          req_d.adr = {cpu_req_i.addr[wb_pkg::ADDR_W-1:2], 2'b00};
          req_d.dat = cpu_req_i.wdata;
          req_d.cyc = 1'b1;
          req_d.stb = 1'b1;
          if (is_read) begin
            state_d = wb_pkg::LOAD;
            req_d.sel = '1;
            req_d.we = 1'b0;
          end else begin
            state_d = wb_pkg::STORE;
            req_d.sel = cpu_req_i.wstrb;
            req_d.we = 1'b1;
          end
        end
      end
      wb_pkg::LOAD,
      wb_pkg::STORE: begin
        if (wb_rsp_i.ack) begin
          state_d = wb_pkg::IDLE;
          req_d.cyc = 1'b0;
          req_d.stb = 1'b0;
          req_d.we = 1'b0;
          ready_d = 1'b1;
        end else if (req_q.stb && !wb_rsp_i.stall) begin
          // Accepted this cycle, keep cyc until the ack
          req_d.stb = 1'b0;
        end
      end
      default: begin
        state_d = wb_pkg::IDLE;
        req_d.cyc = 1'b0;
        req_d.stb = 1'b0;
        req_d.we = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state_q <= wb_pkg::IDLE;
      req_q <= '0;
      ready_q <= 1'b0;
    end else begin
      state_q <= state_d;
      req_q <= req_d;
      ready_q <= ready_d;
    end
  end

  always_ff @(posedge clock) begin
    if (load_ack) begin
      rdata_q <= wb_rsp_i.dat;
    end
  end

  assign wb_req_o = req_q;

  assign cpu_rsp_o.rdata = rdata_q;
  assign cpu_rsp_o.ready = ready_q;

endmodule

`default_nettype wire

/* hdl/wb_addr_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_addr_decoder (
  input  wire             clock,
  input  wire             reset,
  input  wb_pkg::wb_req_t wb_req_i,
  output wb_pkg::wb_rsp_t wb_rsp_o,
  output wb_pkg::wb_req_t ram_req_o,
  input  wb_pkg::wb_rsp_t ram_rsp_i,
  output wb_pkg::wb_req_t reg_req_o,
  input  wb_pkg::wb_rsp_t reg_rsp_i
);

  logic [wb_pkg::ADDR_W-wb_pkg::PAGE_LSB-1:0] page;

  logic ram_hit;
  logic reg_hit;
  logic unmapped;
  logic unmap_ack_q;

  assign page = wb_req_i.adr[wb_pkg::ADDR_W-1:wb_pkg::PAGE_LSB];

  assign ram_hit = (page == wb_pkg::RAM_BASE[wb_pkg::ADDR_W-1:wb_pkg::PAGE_LSB]);
  assign reg_hit = (page == wb_pkg::REG_BASE[wb_pkg::ADDR_W-1:wb_pkg::PAGE_LSB]);
  assign unmapped = !ram_hit && !reg_hit;

  always_comb begin
    ram_req_o = wb_req_i;
    ram_req_o.stb = wb_req_i.stb && ram_hit;
    reg_req_o = wb_req_i;
    reg_req_o.stb = wb_req_i.stb && reg_hit;
  end

  // Unmapped pages answer on their own, one cycle after stb
  always_ff @(posedge clock) begin
    if (!reset) begin
      unmap_ack_q <= 1'b0;
    end else begin
      unmap_ack_q <= wb_req_i.cyc && wb_req_i.stb && unmapped;
    end
  end

  // Address is held by the master until the ack, so it can steer the reply
  always_comb begin
    if (ram_hit) begin
      wb_rsp_o = ram_rsp_i;
    end else if (reg_hit) begin
      wb_rsp_o = reg_rsp_i;
    end else begin
      wb_rsp_o.dat = '0;
      wb_rsp_o.ack = unmap_ack_q;
      wb_rsp_o.stall = 1'b0;
    end
  end

endmodule

`default_nettype wire

/* hdl/wb_sram.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_sram (
  input  wire             clock,
  input  wire             reset,
  input  wb_pkg::wb_req_t wb_req_i,
  output wb_pkg::wb_rsp_t wb_rsp_o,
  input  wb_pkg::wait_t   wait_i,
  output logic            access_done_o
);

  wb_pkg::word_t mem [wb_pkg::RAM_WORDS];

  logic [wb_pkg::RAM_IDX_W-1:0] idx;

  logic req;
  logic stall;
  logic accept;
  logic stalling_q;
  wb_pkg::wait_t cnt_q;
  logic ack_q;
  wb_pkg::word_t rdata_q;

  assign idx = wb_req_i.adr[wb_pkg::RAM_IDX_W+1:2];
  assign req = wb_req_i.cyc && wb_req_i.stb;

  // First stb cycle looks at wait_i directly, later ones at the counter
  assign stall = req && (stalling_q ? (cnt_q != '0) : (wait_i != '0));
  assign accept = req && !stall;

  always_ff @(posedge clock) begin
    if (!reset) begin
      stalling_q <= 1'b0;
      cnt_q <= '0;
      ack_q <= 1'b0;
    end else begin
      ack_q <= accept;
      if (accept) begin
        stalling_q <= 1'b0;
      end else if (stall && !stalling_q) begin
        stalling_q <= 1'b1;
        cnt_q <= wait_i - wb_pkg::wait_t'(1);
      end else if (stall) begin
        cnt_q <= cnt_q - wb_pkg::wait_t'(1);
      end
    end
  end

  // Byte lane writes
  always_ff @(posedge clock) begin
    if (accept && wb_req_i.we) begin
      for (int i = 0; i < wb_pkg::STRB_W; i++) begin
        if (wb_req_i.sel[i]) begin
          mem[idx][8*i +: 8] <= wb_req_i.dat[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      rdata_q <= mem[idx];
    end
  end

  assign wb_rsp_o.dat = rdata_q;
  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.stall = stall;

  assign access_done_o = ack_q;

endmodule

`default_nettype wire

/* hdl/wb_timing_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_timing_regs (
  input  wire             clock,
  input  wire             reset,
  input  wb_pkg::wb_req_t wb_req_i,
  output wb_pkg::wb_rsp_t wb_rsp_o,
  input  wire             access_done_i,
  output wb_pkg::wait_t   wait_o
);

  logic [wb_pkg::PAGE_LSB-1:0] ofs;

  logic req;
  logic wr;
  wb_pkg::wait_t wait_q;
  wb_pkg::word_t scratch_q;
  wb_pkg::word_t count_q;
  wb_pkg::word_t rd_mux;
  wb_pkg::word_t rdata_q;
  logic ack_q;

  assign ofs = {wb_req_i.adr[wb_pkg::PAGE_LSB-1:2], 2'b00};
  assign req = wb_req_i.cyc && wb_req_i.stb;
  assign wr = req && wb_req_i.we;

  always_ff @(posedge clock) begin
    if (!reset) begin
      wait_q <= '0;
      scratch_q <= '0;
      count_q <= '0;
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
      if (wr && ofs == wb_pkg::REG_WAIT_OFS && wb_req_i.sel[0]) begin
        wait_q <= wb_req_i.dat[wb_pkg::WAIT_W-1:0];
      end
      if (wr && ofs == wb_pkg::REG_SCRATCH_OFS) begin
        for (int i = 0; i < wb_pkg::STRB_W; i++) begin
          if (wb_req_i.sel[i]) begin
            scratch_q[8*i +: 8] <= wb_req_i.dat[8*i +: 8];
          end
        end
      end
      // Completed RAM accesses
      if (access_done_i) begin
        count_q <= count_q + wb_pkg::word_t'(1);
      end
    end
  end

  always_comb begin
    case (ofs)
      wb_pkg::REG_WAIT_OFS: rd_mux = wb_pkg::word_t'(wait_q);
      wb_pkg::REG_SCRATCH_OFS: rd_mux = scratch_q;
      wb_pkg::REG_COUNT_OFS: rd_mux = count_q;
      default: rd_mux = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (req) begin
      rdata_q <= rd_mux;
    end
  end

  assign wb_rsp_o.dat = rdata_q;
  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.stall = 1'b0;

  assign wait_o = wait_q;

endmodule

`default_nettype wire

/* hdl/wb_subsystem.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_subsystem (
  input  wire              clock,
  input  wire              reset,
  input  wb_pkg::cpu_req_t cpu_req_i,
  output wb_pkg::cpu_rsp_t cpu_rsp_o
);

  // Master side
  wb_pkg::wb_req_t wb_req;
  wb_pkg::wb_rsp_t wb_rsp;

  // Slave side
  wb_pkg::wb_req_t ram_req;
  wb_pkg::wb_rsp_t ram_rsp;
  wb_pkg::wb_req_t reg_req;
  wb_pkg::wb_rsp_t reg_rsp;

  wb_pkg::wait_t ram_wait;
  logic ram_done;

  wb_master_bridge u_bridge (
    .clock     (clock),
    .reset     (reset),
    .cpu_req_i (cpu_req_i),
    .cpu_rsp_o (cpu_rsp_o),
    .wb_req_o  (wb_req),
    .wb_rsp_i  (wb_rsp)
  );

  wb_addr_decoder u_decoder (
    .clock     (clock),
    .reset     (reset),
    .wb_req_i  (wb_req),
    .wb_rsp_o  (wb_rsp),
    .ram_req_o (ram_req),
    .ram_rsp_i (ram_rsp),
    .reg_req_o (reg_req),
    .reg_rsp_i (reg_rsp)
  );

  wb_sram u_sram (
    .clock         (clock),
    .reset         (reset),
    .wb_req_i      (ram_req),
    .wb_rsp_o      (ram_rsp),
    .wait_i        (ram_wait),
    .access_done_o (ram_done)
  );

  wb_timing_regs u_regs (
    .clock         (clock),
    .reset         (reset),
    .wb_req_i      (reg_req),
    .wb_rsp_o      (reg_rsp),
    .access_done_i (ram_done),
    .wait_o        (ram_wait)
  );

endmodule

`default_nettype wire

/* test/wb_subsystem_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_subsystem_assert (
  input wire              clock,
  input wire              reset,
  input wb_pkg::wb_req_t  wb_req_i,
  input wb_pkg::wb_rsp_t  wb_rsp_i,
  input wb_pkg::cpu_rsp_t cpu_rsp_i
);

  // Number of failed assertions
  int unsigned fail_count = 0;

  stb_with_cyc: assert property (@(posedge clock) disable iff (!reset)
    wb_req_i.stb |-> wb_req_i.cyc)
    else begin
      fail_count++;
      $error("stb high without cyc");
    end

  // Master holds the request while the slave stalls
  hold_under_stall: assert property (@(posedge clock) disable iff (!reset)
    wb_req_i.stb && wb_rsp_i.stall |=> wb_req_i.stb &&
      $stable({wb_req_i.adr, wb_req_i.dat, wb_req_i.sel, wb_req_i.we}))
    else begin
      fail_count++;
      $error("request changed under stall");
    end

  ready_pulse: assert property (@(posedge clock) disable iff (!reset)
    cpu_rsp_i.ready |=> !cpu_rsp_i.ready)
    else begin
      fail_count++;
      $error("ready held longer than one cycle");
    end

  ack_after_cyc: assert property (@(posedge clock) disable iff (!reset)
    wb_rsp_i.ack |-> $past(wb_req_i.cyc))
    else begin
      fail_count++;
      $error("ack without cyc in the cycle before");
    end

endmodule

bind wb_subsystem wb_subsystem_assert u_assert (
  .clock     (clock),
  .reset     (reset),
  .wb_req_i  (wb_req),
  .wb_rsp_i  (wb_rsp),
  .cpu_rsp_i (cpu_rsp_o)
);

`default_nettype wire

/* test/tb_wb_subsystem.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_wb_subsystem;

  localparam int CLK_PERIOD = 8;
  localparam int RESET_CYCLES = 4;
  localparam int ACCESS_LIMIT = 32;
  // Upper bound on accesses over all tests
  localparam int MAX_ACCESSES = 200;
  // Slowest access is 3 + 15 plus 2 idle edges
  localparam int WORST_CYCLES = 20;
  localparam wb_pkg::addr_t WIN_BASE = wb_pkg::RAM_BASE + 32'h100;
  localparam wb_pkg::addr_t UNMAPPED = 32'h2000_0000;

  logic clock;
  logic reset;
  wb_pkg::cpu_req_t cpu_req;
  wb_pkg::cpu_rsp_t cpu_rsp;

  logic [31:0] lfsr_q;
  wb_pkg::word_t ram_model [16];
  wb_pkg::word_t scratch_model;
  wb_pkg::wait_t wait_model;
  wb_pkg::word_t count_model;

  wb_subsystem DUT (
    .clock     (clock),
    .reset     (reset),
    .cpu_req_i (cpu_req),
    .cpu_rsp_o (cpu_rsp)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped");
  endtask

  initial begin
    #(CLK_PERIOD * (RESET_CYCLES + MAX_ACCESSES * WORST_CYCLES));
    fail_run("Watchdog expired before the tests finished");
  end

  task automatic check_word(input string name, input wb_pkg::word_t expected,
                            input wb_pkg::word_t actual);
    if (actual !== expected) begin
      fail_run($sformatf("Mismatch %s: expected %h, got %h", name, expected, actual));
    end
  endtask

  task automatic check_wait(input string name, input wb_pkg::wait_t expected,
                            input wb_pkg::wait_t actual);
    if (actual !== expected) begin
      fail_run($sformatf("Mismatch %s: expected %h, got %h", name, expected, actual));
    end
  endtask

  task automatic check_latency(input string name, input int expected, input int actual);
    if (actual != expected) begin
      fail_run($sformatf("Mismatch %s: expected %h, got %h", name, expected, actual));
    end
  endtask

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic wb_pkg::word_t take_bits(input int n);
    wb_pkg::word_t value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      value = {value[30:0], lfsr_q[0]};
    end
    return value;
  endfunction

  function automatic wb_pkg::word_t merge_bytes(input wb_pkg::word_t old_word,
                                                input wb_pkg::word_t new_word,
                                                input wb_pkg::strb_t strb);
    wb_pkg::word_t result;
    result = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        result[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return result;
  endfunction

  // Cycles are counted from the edge that drives valid to the first edge with ready high
  task automatic bus_access(input wb_pkg::addr_t addr, input wb_pkg::word_t wdata,
                            input wb_pkg::strb_t wstrb, output wb_pkg::word_t rdata,
                            output int cycles);
    @(posedge clock);
    cpu_req <= '{valid: 1'b1, addr: addr, wdata: wdata, wstrb: wstrb};
    cycles = 0;
    do begin
      @(posedge clock);
      @(negedge clock);
      cycles++;
      if (cycles > ACCESS_LIMIT) begin
        fail_run($sformatf("No ready within %0d cycles for address %h", ACCESS_LIMIT, addr));
      end
    end while (!cpu_rsp.ready);
    rdata = cpu_rsp.rdata;
    @(posedge clock);
    cpu_req.valid <= 1'b0;
  endtask

  task automatic ram_write(input int slot, input logic [1:0] low, input wb_pkg::word_t data,
                           input wb_pkg::strb_t strb);
    wb_pkg::word_t rdata;
    int cycles;
    bus_access(WIN_BASE + wb_pkg::addr_t'(slot * 4 + low), data, strb, rdata, cycles);
    ram_model[slot] = merge_bytes(ram_model[slot], data, strb);
    count_model++;
    check_latency("RAM write latency", 3 + wait_model, cycles);
  endtask

  task automatic ram_read(input int slot, input logic [1:0] low);
    wb_pkg::word_t rdata;
    int cycles;
    bus_access(WIN_BASE + wb_pkg::addr_t'(slot * 4 + low), '0, '0, rdata, cycles);
    count_model++;
    check_word($sformatf("RAM slot %0d", slot), ram_model[slot], rdata);
    check_latency("RAM read latency", 3 + wait_model, cycles);
  endtask

  task automatic reg_write(input logic [11:0] ofs, input wb_pkg::word_t data,
                           input wb_pkg::strb_t strb);
    wb_pkg::word_t rdata;
    int cycles;
    bus_access(wb_pkg::REG_BASE + ofs, data, strb, rdata, cycles);
    if (ofs == wb_pkg::REG_WAIT_OFS) begin
      wait_model = data[wb_pkg::WAIT_W-1:0];
    end else if (ofs == wb_pkg::REG_SCRATCH_OFS) begin
      scratch_model = merge_bytes(scratch_model, data, strb);
    end
    check_latency("register write latency", 3, cycles);
  endtask

  task automatic reg_read(input logic [11:0] ofs, input wb_pkg::word_t expected);
    wb_pkg::word_t rdata;
    int cycles;
    bus_access(wb_pkg::REG_BASE + ofs, '0, '0, rdata, cycles);
    check_word($sformatf("register %h", ofs), expected, rdata);
    check_latency("register read latency", 3, cycles);
  endtask

  task automatic wait_readback();
    wb_pkg::word_t rdata;
    int cycles;
    bus_access(wb_pkg::REG_BASE + wb_pkg::REG_WAIT_OFS, '0, '0, rdata, cycles);
    check_wait("WAIT", wait_model, wb_pkg::wait_t'(rdata));
    check_word("WAIT upper bits", '0, rdata >> wb_pkg::WAIT_W);
  endtask

  task automatic test_reset_values();
    wait_readback();
    reg_read(wb_pkg::REG_SCRATCH_OFS, scratch_model);
    reg_read(wb_pkg::REG_COUNT_OFS, count_model);
  endtask

  task automatic test_ram_strobes();
    wb_pkg::addr_t addr;
    for (int i = 0; i < 16; i++) begin
      addr = WIN_BASE + wb_pkg::addr_t'(i * 4);
      ram_write(i, 2'b00, {addr[15:0], addr[31:16]} ^ 32'h5ac3_3ca5, 4'hf);
    end
    ram_write(3, 2'b11, 32'h1122_3344, 4'b0101);
    ram_write(5, 2'b10, 32'haabb_ccdd, 4'b1000);
    ram_read(3, 2'b01);
    ram_read(5, 2'b11);
    ram_read(0, 2'b00);
  endtask

  task automatic test_wait_latency();
    wb_pkg::wait_t waits [3] = '{4'd0, 4'd3, 4'd15};
    foreach (waits[i]) begin
      reg_write(wb_pkg::REG_WAIT_OFS, wb_pkg::word_t'(waits[i]), 4'hf);
      wait_readback();
      ram_read(i + 2, 2'b00);
      reg_read(wb_pkg::REG_SCRATCH_OFS, scratch_model);
    end
  endtask

  task automatic test_scratch_count();
    reg_write(wb_pkg::REG_SCRATCH_OFS, 32'h0123_4567, 4'hf);
    reg_write(wb_pkg::REG_SCRATCH_OFS, 32'hfedc_ba98, 4'b0110);
    reg_read(wb_pkg::REG_SCRATCH_OFS, scratch_model);
    reg_read(wb_pkg::REG_COUNT_OFS, count_model);
    reg_read(wb_pkg::REG_COUNT_OFS, count_model);
    ram_read(7, 2'b10);
    reg_read(wb_pkg::REG_COUNT_OFS, count_model);
  endtask

  task automatic test_unmapped();
    wb_pkg::word_t rdata;
    int cycles;
    bus_access(UNMAPPED + 32'h40, '0, '0, rdata, cycles);
    check_word("unmapped read data", '0, rdata);
    check_latency("unmapped read latency", 3, cycles);
    // These alias the window base in RAM and SCRATCH if the page match is wrong
    bus_access(32'h0000_1100, 32'hffff_ffff, 4'hf, rdata, cycles);
    bus_access(32'h1000_1004, 32'hffff_ffff, 4'hf, rdata, cycles);
    bus_access(UNMAPPED + 32'h100, 32'hffff_ffff, 4'hf, rdata, cycles);
    check_latency("unmapped write latency", 3, cycles);
    ram_read(0, 2'b00);
    reg_read(wb_pkg::REG_SCRATCH_OFS, scratch_model);
    reg_read(wb_pkg::REG_COUNT_OFS, count_model);
  endtask

  task automatic test_random_mix();
    wb_pkg::word_t op;
    wb_pkg::word_t slot;
    wb_pkg::word_t low;
    wb_pkg::word_t strb;
    wb_pkg::word_t data;
    repeat (60) begin
      op = take_bits(2);
      if (op == 0) begin
        data = take_bits(4);
        reg_write(wb_pkg::REG_WAIT_OFS, data, 4'hf);
      end else if (op == 1) begin
        strb = take_bits(4);
        data = take_bits(32);
        if (strb == 0) begin
          reg_read(wb_pkg::REG_SCRATCH_OFS, scratch_model);
        end else begin
          reg_write(wb_pkg::REG_SCRATCH_OFS, data, strb[3:0]);
        end
      end else begin
        slot = take_bits(4);
        low = take_bits(2);
        strb = take_bits(4);
        if (strb == 0) begin
          ram_read(int'(slot), low[1:0]);
        end else begin
          data = take_bits(32);
          ram_write(int'(slot), low[1:0], data, strb[3:0]);
        end
      end
    end
    reg_read(wb_pkg::REG_COUNT_OFS, count_model);
  endtask

  initial begin
    reset = 1'b0;
    cpu_req = '0;
    lfsr_q = 32'h89908ae1;
    scratch_model = '0;
    wait_model = '0;
    count_model = '0;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b1;
    test_reset_values();
    test_ram_strobes();
    test_wait_latency();
    test_scratch_count();
    test_unmapped();
    test_random_mix();
    // Let the assertions of the last edge finish
    @(posedge clock);
    @(negedge clock);
    if (DUT.u_assert.fail_count != 0) begin
      fail_run("Protocol assertions failed during the run");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* flist.f */
hdl/wb_pkg.sv
hdl/wb_master_bridge.sv
hdl/wb_addr_decoder.sv
hdl/wb_sram.sv
hdl/wb_timing_regs.sv
hdl/wb_subsystem.sv
test/wb_subsystem_assert.sv
test/tb_wb_subsystem.sv

/* Bender.yml */
package:
  name: wb_subsystem

sources:
  - files:
      - hdl/wb_pkg.sv
      - hdl/wb_master_bridge.sv
      - hdl/wb_addr_decoder.sv
      - hdl/wb_sram.sv
      - hdl/wb_timing_regs.sv
      - hdl/wb_subsystem.sv
  - target: test
    files:
      - test/wb_subsystem_assert.sv
      - test/tb_wb_subsystem.sv
